//--- sources.f
common/mem_pkg.sv
hdl/mem_ram.sv
mover/mem_write_engine.sv
mover/mem_read_engine.sv
hdl/mem_stats.sv
hdl/mem_top.sv
verif/tb_mem_top.sv

//--- run.sh
#!/bin/sh
# compile with verilator and run the testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module tb_mem_top -o tb_mem_top
out=$(./obj_dir/tb_mem_top)
echo "$out"
if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

//--- verif/tb_mem_top.sv
`timescale 1ns/1ps

module tb_mem_top
  import mem_pkg::*;
();

  localparam int MEM_WORDS = 256;
  localparam int MEM_BYTES = MEM_WORDS * DATA_BYTES;
  localparam int NUM_OPS   = 14;
  localparam int LIMIT     = NUM_OPS * 200 + 1000;   // watchdog budget in cycles

  typedef struct packed {
    logic       is_write;
    addr_t      addr;
    len_t       len;
    logic [7:0] seed;                      // data pattern of a write
    logic       exp_err;                   // range error expected
  } op_t;

  logic        user_clk = 1'b0;
  logic        user_aresetn;
  mem_cmd_t    wr_cmd, rd_cmd;
  logic        wr_cmd_valid, wr_cmd_ready, rd_cmd_valid, rd_cmd_ready;
  mem_beat_t   wr_data, rd_data;
  logic        wr_data_valid, wr_data_ready, rd_data_valid, rd_data_ready;
  mem_sts_t    wr_sts, rd_sts;
  logic        wr_sts_valid, wr_sts_ready, rd_sts_valid, rd_sts_ready;
  stat_word_t [STAT_WORDS-1:0] status_reg;

  logic [7:0]  model [MEM_BYTES];          // byte image of the ram
  mem_beat_t   rd_q [$];                   // beats seen on rd_data
  mem_sts_t    wr_sts_q [$];
  mem_sts_t    rd_sts_q [$];
  stat_word_t [STAT_WORDS-1:0] exp_cnt = '0;   // own event counts
  int          err_data = 0;
  int          err_sts = 0;
  int          err_stat = 0;
  int          err_proto = 0;
  int unsigned seed_val;

  op_t ops [NUM_OPS] = '{
    '{1'b1, 32'h000, 23'd64,  8'h11, 1'b0},    // plain write
    '{1'b0, 32'h000, 23'd64,  8'h00, 1'b0},
    '{1'b1, 32'h100, 23'd29,  8'h42, 1'b0},    // partial keep on last beat
    '{1'b0, 32'h100, 23'd32,  8'h00, 1'b0},    // tail bytes keep the fill
    '{1'b0, 32'h0f8, 23'd45,  8'h00, 1'b0},    // partial last beat
    '{1'b1, 32'h7f8, 23'd16,  8'h5a, 1'b1},    // runs past the end
    '{1'b0, 32'h7f0, 23'd16,  8'h00, 1'b0},    // top words unchanged
    '{1'b0, 32'h7f8, 23'd9,   8'h00, 1'b1},
    '{1'b0, 32'h040, 23'd0,   8'h00, 1'b1},    // zero length
    '{1'b1, 32'h300, 23'd200, 8'h77, 1'b0},    // long burst
    '{1'b0, 32'h300, 23'd200, 8'h00, 1'b0},
    '{1'b0, 32'h000, 23'd288, 8'h00, 1'b0},
    '{1'b1, 32'h010, 23'd3,   8'h99, 1'b0},    // single short beat
    '{1'b0, 32'h008, 23'd24,  8'h00, 1'b0}
  };

  always #20 user_clk = ~user_clk;         // 40 ns period

  mem_top #(.MEM_WORDS(MEM_WORDS)) UUT (.*);

  function automatic logic [7:0] fill_byte(int a);
    return 8'((a * 37) ^ (a >> 5));        // every address bit takes part
  endfunction

  function automatic logic [7:0] pattern_byte(logic [7:0] seed, int i);
    return 8'((int'(seed) * 7) + (i * 13) + (i >> 4));
  endfunction

  // random readies, outputs recorded mid cycle where they are stable
  always @(negedge user_clk) begin
    rd_data_ready = ($urandom % 4) != 0;
    wr_sts_ready  = 1'($urandom % 2);
    rd_sts_ready  = 1'($urandom % 2);
    if (user_aresetn) begin
      if (rd_data_valid && rd_data_ready) begin
        rd_q.push_back(rd_data);
        exp_cnt[stat_rd_words] += 1;
        if (rd_data.last) exp_cnt[stat_rd_pkts] += 1;
        exp_cnt[stat_rd_bytes] += stat_word_t'($countones(rd_data.keep));
      end
      if (wr_sts_valid && wr_sts_ready) begin
        wr_sts_q.push_back(wr_sts);
        exp_cnt[stat_wr_sts] += 1;
        if (!wr_sts.okay) exp_cnt[stat_wr_sts_err] += 1;
      end
      if (rd_sts_valid && rd_sts_ready) begin
        rd_sts_q.push_back(rd_sts);
        exp_cnt[stat_rd_sts] += 1;
        if (!rd_sts.okay) exp_cnt[stat_rd_sts_err] += 1;
      end
    end
  end

  // ready only moves on rising edges, so the falling edge value holds
  task automatic push_cmd(input logic is_write, input mem_cmd_t c);
    @(negedge user_clk);
    if (is_write) begin
      wr_cmd       = c;
      wr_cmd_valid = 1'b1;
    end else begin
      rd_cmd       = c;
      rd_cmd_valid = 1'b1;
    end
    while (!(is_write ? wr_cmd_ready : rd_cmd_ready)) @(negedge user_clk);
    @(negedge user_clk);                   // transfer on the edge before
    wr_cmd_valid = 1'b0;
    rd_cmd_valid = 1'b0;
    if (is_write) exp_cnt[stat_wr_cmd] += 1;
    else exp_cnt[stat_rd_cmd] += 1;
  endtask

  task automatic await_status(input logic is_write, input logic exp_err);
    mem_sts_t got;
    mem_sts_t exp;
    exp = exp_err ? mem_sts_t'(8'h40) : mem_sts_t'(8'h80);   // range_err or okay
    if (is_write) begin
      while (wr_sts_q.size() == 0) @(negedge user_clk);
      got = wr_sts_q.pop_front();
    end else begin
      while (rd_sts_q.size() == 0) @(negedge user_clk);
      got = rd_sts_q.pop_front();
    end
    if (got !== exp) begin
      err_sts++;
      $display("error %s: got %h expected %h", is_write ? "wr_sts" : "rd_sts", got, exp);
    end
  endtask

  task automatic write_burst(input addr_t addr, input len_t len, input logic [7:0] seed,
                             input logic fill, input logic exp_err);
    mem_cmd_t  c;
    mem_beat_t beat;
    int        nbeats;
    int        idx;
    c.addr = addr;
    c.len  = len;
    nbeats = (int'(len) + 7) / 8;
    push_cmd(1'b1, c);
    for (int k = 0; k < nbeats; k++) begin
      beat = '0;
      for (int b = 0; b < DATA_BYTES; b++) begin
        idx = k * DATA_BYTES + b;
        if (idx < int'(len)) begin
          beat.keep[b] = 1'b1;             // bytes past len stay masked
          beat.data[b*8 +: 8] = fill ? fill_byte(int'(addr) + idx) : pattern_byte(seed, idx);
        end
      end
      beat.last     = (k == nbeats - 1);
      wr_data       = beat;
      wr_data_valid = 1'b1;
      while (!wr_data_ready) @(negedge user_clk);
      @(negedge user_clk);
      exp_cnt[stat_wr_words] += 1;
      if (beat.last) exp_cnt[stat_wr_pkts] += 1;
      exp_cnt[stat_wr_bytes] += stat_word_t'($countones(beat.keep));
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (!exp_err && beat.keep[b]) begin
          model[int'(addr) + k * DATA_BYTES + b] = beat.data[b*8 +: 8];
        end
      end
    end
    wr_data_valid = 1'b0;
    await_status(1'b1, exp_err);
  endtask

  task automatic read_check(input addr_t addr, input len_t len, input logic exp_err);
    mem_cmd_t  c;
    mem_beat_t beat;
    keep_t     exp_keep;
    int        nbeats;
    int        idx;
    c.addr = addr;
    c.len  = len;
    nbeats = exp_err ? 0 : (int'(len) + 7) / 8;   // rejected reads give no beats
    push_cmd(1'b0, c);
    await_status(1'b0, exp_err);             // status trails every beat
    if (rd_q.size() != nbeats) begin
      err_proto++;
      $display("read at %h returned %0d beats, %0d expected", addr, rd_q.size(), nbeats);
    end
    for (int k = 0; k < nbeats; k++) begin
      if (rd_q.size() == 0) break;
      beat = rd_q.pop_front();
      if (k == nbeats - 1 && (int'(len) % 8) != 0) exp_keep = keep_t'((1 << (int'(len) % 8)) - 1);
      else exp_keep = '1;
      if (beat.keep !== exp_keep) begin
        err_data++;
        $display("error rd_data.keep: got %h expected %h", beat.keep, exp_keep);
      end
      if (beat.last !== (k == nbeats - 1)) begin
        err_data++;
        $display("error rd_data.last: got %h expected %h", beat.last, k == nbeats - 1);
      end
      for (int b = 0; b < DATA_BYTES; b++) begin
        idx = int'(addr) + k * DATA_BYTES + b;
        if (exp_keep[b] && beat.data[b*8 +: 8] !== model[idx]) begin
          err_data++;
          $display("error rd_data.data at byte %h: got %h expected %h",
                   idx, beat.data[b*8 +: 8], model[idx]);
        end
      end
    end
    rd_q.delete();
  endtask

  task automatic compare_stats();
    stat_idx_e idx;
    for (int i = 0; i < STAT_WORDS; i++) begin
      idx = stat_idx_e'(i);
      if (status_reg[i] !== exp_cnt[i]) begin
        err_stat++;
        $display("error status_reg[%s]: got %h expected %h", idx.name(), status_reg[i], exp_cnt[i]);
      end
    end
  endtask

  initial begin
    repeat (LIMIT) @(posedge user_clk);
    $display("timeout after %0d cycles, the DUT stopped responding", LIMIT);
    $display("errors: data %0d status %0d stats %0d protocol %0d",
             err_data, err_sts, err_stat, err_proto);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed_val      = $urandom(32'h1a25);
    user_aresetn  = 1'b0;
    wr_cmd        = '0;
    rd_cmd        = '0;
    wr_data       = '0;
    wr_cmd_valid  = 1'b0;
    rd_cmd_valid  = 1'b0;
    wr_data_valid = 1'b0;
    rd_data_ready = 1'b0;
    wr_sts_ready  = 1'b0;
    rd_sts_ready  = 1'b0;
    repeat (3) @(posedge user_clk);
    @(negedge user_clk);
    user_aresetn = 1'b1;
    write_burst('0, len_t'(MEM_BYTES), 8'h00, 1'b1, 1'b0);   // ram starts undefined
    for (int i = 0; i < NUM_OPS; i++) begin
      if (ops[i].is_write) write_burst(ops[i].addr, ops[i].len, ops[i].seed, 1'b0, ops[i].exp_err);
      else read_check(ops[i].addr, ops[i].len, ops[i].exp_err);
    end
    repeat (8) @(negedge user_clk);        // let status_reg catch up
    if (wr_sts_q.size() != 0 || rd_sts_q.size() != 0 || rd_q.size() != 0) begin
      err_proto++;
      $display("extra status or read beats arrived after the last command");
    end
    compare_stats();
    $display("errors: data %0d status %0d stats %0d protocol %0d",
             err_data, err_sts, err_stat, err_proto);
    if (err_data + err_sts + err_stat + err_proto == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/mem_top.sv
`timescale 1ns/1ps

module mem_top
  import mem_pkg::*;
#(
  parameter int MEM_WORDS  = 256,                  // ram depth in beats
  parameter int DATA_BYTES = mem_pkg::DATA_BYTES   // bytes per beat
) (
  input  logic                             user_clk,
  input  logic                             user_aresetn,
  input  mem_cmd_t                         wr_cmd,
  input  logic                             wr_cmd_valid,
  output logic                             wr_cmd_ready,
  input  mem_beat_t                        wr_data,
  input  logic                             wr_data_valid,
  output logic                             wr_data_ready,
  output mem_sts_t                         wr_sts,
  output logic                             wr_sts_valid,
  input  logic                             wr_sts_ready,
  input  mem_cmd_t                         rd_cmd,
  input  logic                             rd_cmd_valid,
  output logic                             rd_cmd_ready,
  output mem_beat_t                        rd_data,
  output logic                             rd_data_valid,
  input  logic                             rd_data_ready,
  output mem_sts_t                         rd_sts,
  output logic                             rd_sts_valid,
  input  logic                             rd_sts_ready,
  output stat_word_t [STAT_WORDS-1:0]      status_reg
);

  localparam int ADDR_W = $clog2(MEM_WORDS);

  logic              a_en;                 // port a, write side
  keep_t             a_we;
  logic [ADDR_W-1:0] a_addr;
  data_t             a_wdata;
  logic              b_en;                 // port b, read side
  logic [ADDR_W-1:0] b_addr;
  data_t             b_rdata;

  logic wr_cmd_fire, wr_beat_fire, wr_sts_fire;
  logic rd_cmd_fire, rd_beat_fire, rd_sts_fire;
  stat_events_t events;

  assign wr_cmd_fire  = wr_cmd_valid & wr_cmd_ready;
  assign wr_beat_fire = wr_data_valid & wr_data_ready;
  assign wr_sts_fire  = wr_sts_valid & wr_sts_ready;
  assign rd_cmd_fire  = rd_cmd_valid & rd_cmd_ready;
  assign rd_beat_fire = rd_data_valid & rd_data_ready;
  assign rd_sts_fire  = rd_sts_valid & rd_sts_ready;

  // status without okay counts as an error
  assign events = '{
    wr_cmd:     wr_cmd_fire,
    wr_sts:     wr_sts_fire,
    wr_sts_err: wr_sts_fire & ~wr_sts.okay,
    rd_cmd:     rd_cmd_fire,
    rd_sts:     rd_sts_fire,
    rd_sts_err: rd_sts_fire & ~rd_sts.okay,
    wr_words:   wr_beat_fire,
    wr_pkts:    wr_beat_fire & wr_data.last,
    wr_bytes:   wr_beat_fire,
    rd_words:   rd_beat_fire,
    rd_pkts:    rd_beat_fire & rd_data.last,
    rd_bytes:   rd_beat_fire
  };

  mem_write_engine #(.MEM_WORDS(MEM_WORDS), .DATA_BYTES(DATA_BYTES)) u_wr (
    .user_clk, .user_aresetn,
    .cmd(wr_cmd), .cmd_valid(wr_cmd_valid), .cmd_ready(wr_cmd_ready),
    .data(wr_data), .data_valid(wr_data_valid), .data_ready(wr_data_ready),
    .sts(wr_sts), .sts_valid(wr_sts_valid), .sts_ready(wr_sts_ready),
    .ram_en(a_en), .ram_we(a_we), .ram_addr(a_addr), .ram_wdata(a_wdata)
  );

  mem_read_engine #(.MEM_WORDS(MEM_WORDS), .DATA_BYTES(DATA_BYTES)) u_rd (
    .user_clk, .user_aresetn,
    .cmd(rd_cmd), .cmd_valid(rd_cmd_valid), .cmd_ready(rd_cmd_ready),
    .data(rd_data), .data_valid(rd_data_valid), .data_ready(rd_data_ready),
    .sts(rd_sts), .sts_valid(rd_sts_valid), .sts_ready(rd_sts_ready),
    .ram_en(b_en), .ram_addr(b_addr), .ram_rdata(b_rdata)
  );

  mem_ram #(.MEM_WORDS(MEM_WORDS), .DATA_BYTES(DATA_BYTES)) u_ram (
    .user_clk,
    .a_en, .a_we, .a_addr, .a_wdata,
    .b_en, .b_addr, .b_rdata
  );

  mem_stats u_stats (
    .user_clk, .user_aresetn,
    .events,
    .wr_bytes(wr_data.keep),               // keep of the beat in flight
    .rd_bytes(rd_data.keep),
    .status_reg
  );

endmodule

//--- hdl/mem_stats.sv
`timescale 1ns/1ps

module mem_stats
  import mem_pkg::*;
(
  input  logic                        user_clk,
  input  logic                        user_aresetn,
  input  stat_events_t                events,
  input  keep_t                       wr_bytes,     // keep of the write beat
  input  keep_t                       rd_bytes,     // keep of the read beat
  output stat_word_t [STAT_WORDS-1:0] status_reg
);

  stat_word_t [STAT_WORDS-1:0] cnt;         // live counters
  stat_word_t [STAT_WORDS-1:0] inc;         // amount added this cycle
  stat_word_t                  wr_pop;
  stat_word_t                  rd_pop;

  // byte counts from the keep popcount
  assign wr_pop = stat_word_t'($countones(wr_bytes));
  assign rd_pop = stat_word_t'($countones(rd_bytes));

  always_comb begin
    inc[stat_wr_cmd]     = stat_word_t'(events.wr_cmd);
    inc[stat_wr_sts]     = stat_word_t'(events.wr_sts);
    inc[stat_wr_sts_err] = stat_word_t'(events.wr_sts_err);
    inc[stat_rd_cmd]     = stat_word_t'(events.rd_cmd);
    inc[stat_rd_sts]     = stat_word_t'(events.rd_sts);
    inc[stat_rd_sts_err] = stat_word_t'(events.rd_sts_err);
    inc[stat_wr_words]   = stat_word_t'(events.wr_words);
    inc[stat_wr_pkts]    = stat_word_t'(events.wr_pkts);
    inc[stat_wr_bytes]   = events.wr_bytes ? wr_pop : '0;
    inc[stat_rd_words]   = stat_word_t'(events.rd_words);
    inc[stat_rd_pkts]    = stat_word_t'(events.rd_pkts);
    inc[stat_rd_bytes]   = events.rd_bytes ? rd_pop : '0;
  end

  // counters move on the edge of their event
  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      cnt <= '0;
    end else begin
      for (int i = 0; i < STAT_WORDS; i++) begin
        cnt[i] <= cnt[i] + inc[i];         // wraps at 32 bits
      end
    end
  end

  // registered copy, one cycle behind the counters
  always_ff @(posedge user_clk) begin
    status_reg <= cnt;
  end

endmodule

//--- mover/mem_read_engine.sv
`timescale 1ns/1ps

module mem_read_engine
  import mem_pkg::*;
#(
  parameter int MEM_WORDS  = 256,
  parameter int DATA_BYTES = mem_pkg::DATA_BYTES
) (
  input  logic                         user_clk,
  input  logic                         user_aresetn,
  input  mem_cmd_t                     cmd,
  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  output mem_beat_t                    data,
  output logic                         data_valid,
  input  logic                         data_ready,
  output mem_sts_t                     sts,
  output logic                         sts_valid,
  input  logic                         sts_ready,
  output logic                         ram_en,
  output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
  input  data_t                        ram_rdata
);

  localparam int ADDR_W     = $clog2(MEM_WORDS);
  localparam int WB         = $clog2(DATA_BYTES);
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam keep_t KEEP_ALL = '1;

  rd_state_e         state;
  logic [ADDR_W-1:0] rd_addr;              // next word to issue
  len_t              issue_left;           // reads not yet issued
  len_t              ret_left;             // words not yet back from ram
  keep_t             last_keep;            // keep of the final beat
  logic              range_ok;
  logic              cmd_ok;
  len_t              cmd_words;
  logic              cmd_fire, sts_fire, pop, push, room, ret_last;
  logic              p1_valid, p2_valid;   // tracks the ram read latency

  mem_beat_t             fifo [FIFO_DEPTH];
  mem_beat_t             push_beat;
  logic [PTR_W-1:0]      wr_ptr, rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt;

  assign cmd_ready = (state == rs_idle);
  assign sts_valid = (state == rs_status);
  assign cmd_fire  = cmd_valid & cmd_ready;
  assign sts_fire  = sts_valid & sts_ready;

  assign cmd_ok    = cmd_in_range(cmd, MEM_WORDS * DATA_BYTES);
  assign cmd_words = len_t'(({1'b0, cmd.len} + (DATA_BYTES - 1)) >> WB);  // ceil

  // credit check, fifo plus reads in flight must stay within depth
  assign room   = (int'(fifo_cnt) + int'(p1_valid) + int'(p2_valid)) < FIFO_DEPTH;
  assign ram_en = (state == rs_issue) && (issue_left != '0) && room;
  assign ram_addr = rd_addr;

  assign push     = p2_valid;              // ram_rdata valid this cycle
  assign ret_last = (ret_left == len_t'(1));
  assign push_beat = '{data: ram_rdata, keep: ret_last ? last_keep : KEEP_ALL, last: ret_last};

  assign data       = fifo[rd_ptr];
  assign data_valid = (fifo_cnt != '0);
  assign pop        = data_valid & data_ready;

  assign sts = '{okay: range_ok, range_err: ~range_ok, rsvd: '0};

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state    <= rs_idle;
      p1_valid <= 1'b0;
      p2_valid <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      p1_valid <= ram_en;
      p2_valid <= p1_valid;
      if (push) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap at depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      fifo_cnt <= fifo_cnt + ($bits(fifo_cnt))'(push) - ($bits(fifo_cnt))'(pop);
      case (state)
        rs_idle: begin
          if (cmd_fire) state <= cmd_ok ? rs_issue : rs_status;  // bad cmd, no beats
        end
        rs_issue: begin
          if (pop && data.last) state <= rs_status;  // all words have left
        end
        rs_status: begin
          if (sts_fire) state <= rs_idle;
        end
        default: state <= rs_idle;
      endcase
    end
  end

  always_ff @(posedge user_clk) begin
    if (push) fifo[wr_ptr] <= push_beat;
  end

  // command payload and word counters
  always_ff @(posedge user_clk) begin
    if (cmd_fire) begin
      rd_addr    <= cmd.addr[WB +: ADDR_W];
      issue_left <= cmd_words;
      ret_left   <= cmd_words;
      range_ok   <= cmd_ok;
      last_keep  <= (cmd.len[WB-1:0] == '0) ? KEEP_ALL : ~(KEEP_ALL << cmd.len[WB-1:0]);
    end else begin
      if (ram_en) begin
        rd_addr    <= rd_addr + 1'b1;
        issue_left <= issue_left - 1'b1;
      end
      if (push) ret_left <= ret_left - 1'b1;
    end
  end

endmodule

//--- mover/mem_write_engine.sv
`timescale 1ns/1ps

module mem_write_engine
  import mem_pkg::*;
#(
  parameter int MEM_WORDS  = 256,
  parameter int DATA_BYTES = mem_pkg::DATA_BYTES
) (
  input  logic                         user_clk,
  input  logic                         user_aresetn,
  input  mem_cmd_t                     cmd,
  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  input  mem_beat_t                    data,
  input  logic                         data_valid,
  output logic                         data_ready,
  output mem_sts_t                     sts,
  output logic                         sts_valid,
  input  logic                         sts_ready,
  output logic                         ram_en,
  output keep_t                        ram_we,
  output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
  output data_t                        ram_wdata
);

  localparam int ADDR_W = $clog2(MEM_WORDS);
  localparam int WB     = $clog2(DATA_BYTES);   // byte offset bits dropped

  wr_state_e         state;
  logic [ADDR_W-1:0] word_addr;            // next word to write
  logic              range_ok;             // latched range check
  logic              cmd_fire;
  logic              beat_fire;
  logic              sts_fire;

  assign cmd_ready  = (state == ws_idle);
  assign data_ready = (state == ws_data);
  assign sts_valid  = (state == ws_status);

  assign cmd_fire  = cmd_valid & cmd_ready;
  assign beat_fire = data_valid & data_ready;
  assign sts_fire  = sts_valid & sts_ready;

  // beat goes to ram in the cycle it is accepted
  assign ram_en    = beat_fire & range_ok;  // drain only when out of range
  assign ram_we    = data.keep;             // keep is the byte enable
  assign ram_addr  = word_addr;
  assign ram_wdata = data.data;

  assign sts = '{okay: range_ok, range_err: ~range_ok, rsvd: '0};

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state <= ws_idle;
    end else begin
      case (state)
        ws_idle: begin
          if (cmd_fire) state <= ws_data;
        end
        ws_data: begin
          if (beat_fire && data.last) state <= ws_status;  // sts_valid next cycle
        end
        ws_status: begin
          if (sts_fire) state <= ws_idle;
        end
        default: state <= ws_idle;
      endcase
    end
  end

  // address stepping and range flag
  always_ff @(posedge user_clk) begin
    if (cmd_fire) begin
      word_addr <= cmd.addr[WB +: ADDR_W];
      range_ok  <= cmd_in_range(cmd, MEM_WORDS * DATA_BYTES);
    end else if (beat_fire) begin
      word_addr <= word_addr + 1'b1;       // one word per beat
    end
  end

endmodule

//--- hdl/mem_ram.sv
`timescale 1ns/1ps

module mem_ram
  import mem_pkg::*;
#(
  parameter int MEM_WORDS  = 256,
  parameter int DATA_BYTES = mem_pkg::DATA_BYTES
) (
  input  logic                         user_clk,
  input  logic                         a_en,
  input  keep_t                        a_we,
  input  logic [$clog2(MEM_WORDS)-1:0] a_addr,
  input  data_t                        a_wdata,
  input  logic                         b_en,
  input  logic [$clog2(MEM_WORDS)-1:0] b_addr,
  output data_t                        b_rdata
);

  data_t mem [MEM_WORDS];                  // no init, contents start undefined
  data_t rd_q;                             // first read stage

  // byte lanes written only where we is set
  always_ff @(posedge user_clk) begin
    if (a_en) begin
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (a_we[b]) begin
          mem[a_addr][b*8 +: 8] <= a_wdata[b*8 +: 8];
        end
      end
    end
  end

  // two register stages, data two cycles after b_en
  always_ff @(posedge user_clk) begin
    if (b_en) begin
      rd_q <= mem[b_addr];                 // old data on same-cycle write
    end
    b_rdata <= rd_q;                       // output register always enabled
  end

endmodule

//--- common/mem_pkg.sv
package mem_pkg;

  localparam int DATA_BYTES = 8;          // bytes per beat
  localparam int STAT_WORDS = 12;         // number of statistics words

  typedef logic [31:0] addr_t;            // byte address
  typedef logic [22:0] len_t;             // byte length, btt sized
  typedef logic [63:0] data_t;            // beat payload
  typedef logic [7:0]  keep_t;            // one bit per byte lane
  typedef logic [31:0] stat_word_t;       // counter word

  typedef struct packed {
    addr_t addr;                          // start byte, low bits ignored
    len_t  len;                           // bytes to transfer
  } mem_cmd_t;

  typedef struct packed {
    logic       okay;                     // bit 7, transfer done
    logic       range_err;                // bit 6, command rejected
    logic [5:0] rsvd;                     // always zero
  } mem_sts_t;

  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;                          // final beat of the packet
  } mem_beat_t;

  // one strobe per counter, same order as stat_idx_e
  typedef struct packed {
    logic wr_cmd;
    logic wr_sts;
    logic wr_sts_err;
    logic rd_cmd;
    logic rd_sts;
    logic rd_sts_err;
    logic wr_words;
    logic wr_pkts;
    logic wr_bytes;                       // add popcount of write keep
    logic rd_words;
    logic rd_pkts;
    logic rd_bytes;                       // add popcount of read keep
  } stat_events_t;

  typedef enum logic [3:0] {
    stat_wr_cmd, stat_wr_sts, stat_wr_sts_err,
    stat_rd_cmd, stat_rd_sts, stat_rd_sts_err,
    stat_wr_words, stat_wr_pkts, stat_wr_bytes,
    stat_rd_words, stat_rd_pkts, stat_rd_bytes
  } stat_idx_e;

  typedef enum logic [1:0] {ws_idle, ws_data, ws_status} wr_state_e;
  typedef enum logic [1:0] {rs_idle, rs_issue, rs_status} rd_state_e;

  // nonzero length and the last byte inside the memory
  function automatic logic cmd_in_range(mem_cmd_t cmd, int unsigned limit_bytes);
    logic [32:0] end_addr;
    end_addr = {1'b0, cmd.addr} + 33'(cmd.len);  // 33 bits, no wrap
    return (cmd.len != '0) && (end_addr <= 33'(limit_bytes));
  endfunction

endpackage
